//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_dz_top
FILELIST := build.f
OBJ_DIR  := obj_dir
PASS_MSG := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
dz_pkg.sv
dz_apb_regs.sv
dz_countdown.sv
dz_glyph_rom.sv
dz_show.sv
dz_top.sv
tb_dz_top.sv

//--- dz_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dz_apb_regs
    import dz_pkg::*;
#(
    parameter int unsigned STEP_RESET = 1000
)
(
    input  logic              clk,
    input  logic              rst,
    input  dz_apb_req_t       apb_req,
    output dz_apb_rsp_t       apb_rsp,
    output logic              start,
    output logic              pause,
    output dz_digit_t         load_digit,
    output logic [STEP_W-1:0] step_cycles,
    input  dz_status_t        status
);

    logic              access;
    logic              wr_en;
    logic              addr_ok;
    logic              wr_status;
    logic              start_q;
    logic              pause_q;
    dz_digit_t         load_q;
    logic [STEP_W-1:0] step_q;
    dz_word_t          rd_data;

    function automatic dz_digit_t clamp_digit(input dz_word_t value);
        if (value > dz_word_t'(MAX_DIGIT))
            return MAX_DIGIT;
        return dz_digit_t'(value);
    endfunction

    assign access    = apb_req.psel && apb_req.penable;
    assign wr_en     = access && apb_req.pwrite;
    assign wr_status = apb_req.pwrite && (apb_req.paddr == ADDR_STATUS);

    // address decode for read data
    always_comb
    begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (apb_req.paddr)
            ADDR_CTRL:   rd_data = dz_word_t'({pause_q, 1'b0}); // start reads 0
            ADDR_LOAD:   rd_data = dz_word_t'(load_q);
            ADDR_STEP:   rd_data = dz_word_t'(step_q);
            ADDR_STATUS: rd_data = dz_word_t'(status);
            default:     addr_ok = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = access ? rd_data : '0;
    assign apb_rsp.pready  = 1'b1; // no wait states
    assign apb_rsp.pslverr = access && (!addr_ok || wr_status);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_q <= 1'b0;
            pause_q <= 1'b0;
            load_q  <= '0;
            step_q  <= STEP_W'(STEP_RESET);
        end
        else
        begin
            start_q <= 1'b0; // one cycle pulse
            if (wr_en)
            begin
                case (apb_req.paddr)
                    ADDR_CTRL:
                    begin
                        start_q <= apb_req.pwdata[0];
                        pause_q <= apb_req.pwdata[1];
                    end
                    ADDR_LOAD:
                        load_q <= clamp_digit(apb_req.pwdata);
                    ADDR_STEP:
                        step_q <= apb_req.pwdata[STEP_W-1:0];
                    default:
                        ;
                endcase
            end
        end
    end

    assign start       = start_q;
    assign pause       = pause_q;
    assign load_digit  = load_q;
    assign step_cycles = step_q;

endmodule

`default_nettype wire

//--- dz_countdown.sv
`timescale 1ns/100ps
`default_nettype none

module dz_countdown
    import dz_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pause,
    input  dz_digit_t         load_digit,
    input  logic [STEP_W-1:0] step_cycles,
    output dz_status_t        status
);

    logic [STEP_W-1:0] period;
    logic [STEP_W-1:0] timer_q;
    logic              step_hit;
    dz_digit_t         digit_q;
    logic              running_q;
    logic              done_q;

    // zero period behaves as one
    assign period = (step_cycles == '0) ? STEP_W'(1) : step_cycles;

    // >= so a shortened period mid-count still fires
    assign step_hit = (timer_q >= period - STEP_W'(1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            timer_q   <= '0;
            digit_q   <= '0;
            running_q <= 1'b0;
            done_q    <= 1'b0;
        end
        else if (start)
        begin
            timer_q <= '0;
            digit_q <= load_digit;
            if (load_digit == '0)
            begin
                running_q <= 1'b0; // nothing to count
                done_q    <= 1'b1;
            end
            else
            begin
                running_q <= 1'b1;
                done_q    <= 1'b0;
            end
        end
        else if (running_q && !pause)
        begin
            if (step_hit)
            begin
                timer_q <= '0;
                digit_q <= digit_q - dz_digit_t'(1);
                if (digit_q == dz_digit_t'(1))
                begin
                    running_q <= 1'b0;
                    done_q    <= 1'b1;
                end
            end
            else
                timer_q <= timer_q + STEP_W'(1);
        end
    end

    assign status.digit   = digit_q;
    assign status.running = running_q;
    assign status.done    = done_q;

endmodule

`default_nettype wire

//--- dz_glyph_rom.sv
`timescale 1ns/100ps
`default_nettype none

module dz_glyph_rom
    import dz_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  dz_digit_t        digit,
    input  logic             done,
    input  logic [ROW_W-1:0] row_idx,
    output dz_cols_t         cols
);

    dz_cols_t  next_cols;
    dz_glyph_t red_glyph;
    logic      digit_lit;

    // digit 0 stays dark until the count finishes
    assign digit_lit = (digit != '0) && (digit <= MAX_DIGIT);

    always_comb
    begin
        red_glyph = '0;
        if (digit_lit)
            red_glyph = GLYPH_RED[digit];
    end

    always_comb
    begin
        next_cols = '0;
        if (done)
            next_cols.green = GLYPH_GO[row_idx]; // go sign only
        else
            next_cols.red = red_glyph[row_idx];
    end

    // one cycle from row index to column bytes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cols <= '0;
        else
            cols <= next_cols;
    end

endmodule

`default_nettype wire

//--- dz_pkg.sv
`default_nettype none

package dz_pkg;

    localparam int unsigned ADDR_W  = 4;
    localparam int unsigned WORD_W  = 32;
    localparam int unsigned DIGIT_W = 4;
    localparam int unsigned STEP_W  = 16;
    localparam int unsigned ROW_W   = 3;

    typedef logic [ADDR_W-1:0]  dz_addr_t;
    typedef logic [WORD_W-1:0]  dz_word_t;
    typedef logic [DIGIT_W-1:0] dz_digit_t;

    localparam dz_addr_t ADDR_CTRL   = 4'h0; // bit0 start, bit1 pause
    localparam dz_addr_t ADDR_LOAD   = 4'h4;
    localparam dz_addr_t ADDR_STEP   = 4'h8;
    localparam dz_addr_t ADDR_STATUS = 4'hC; // read only

    localparam dz_digit_t MAX_DIGIT = 4'd9;

    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        dz_addr_t paddr;
        dz_word_t pwdata;
    } dz_apb_req_t;

    typedef struct packed {
        dz_word_t prdata;
        logic     pready;
        logic     pslverr;
    } dz_apb_rsp_t;

    typedef struct packed {
        dz_digit_t digit;
        logic      running;
        logic      done;
    } dz_status_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
    } dz_cols_t;

    // one glyph, row 0 first
    typedef logic [0:7][7:0] dz_glyph_t;

    localparam dz_glyph_t [0:9] GLYPH_RED = '{
        '{8'h00, 8'h3C, 8'h24, 8'h24, 8'h24, 8'h24, 8'h3C, 8'h00}, // never lit
        '{8'h00, 8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E},
        '{8'h00, 8'h00, 8'h3C, 8'h04, 8'h04, 8'h3C, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h3C, 8'h24, 8'h24, 8'h24, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h24, 8'h24, 8'h24, 8'h3C, 8'h00, 8'h00},
        '{8'h00, 8'h3C, 8'h20, 8'h3C, 8'h04, 8'h04, 8'h3C, 8'h00},
        '{8'h00, 8'h3C, 8'h20, 8'h3C, 8'h24, 8'h24, 8'h3C, 8'h00},
        '{8'h00, 8'h3C, 8'h04, 8'h08, 8'h10, 8'h10, 8'h10, 8'h00},
        '{8'h00, 8'h3C, 8'h24, 8'h3C, 8'h24, 8'h24, 8'h3C, 8'h00},
        '{8'h00, 8'h3C, 8'h24, 8'h3C, 8'h04, 8'h04, 8'h3C, 8'h00}
    };

    // "GO" in two 3-wide letters
    localparam dz_glyph_t GLYPH_GO =
        '{8'h00, 8'h77, 8'h45, 8'h45, 8'h55, 8'h55, 8'h77, 8'h00};

endpackage

`default_nettype wire

//--- dz_show.sv
`timescale 1ns/100ps
`default_nettype none

module dz_show
    import dz_pkg::*;
#(
    parameter int unsigned SCAN_CYCLES = 4
)
(
    input  logic             clk,
    input  logic             rst,
    input  dz_cols_t         cols_in,
    output logic [ROW_W-1:0] row_idx,
    output logic [7:0]       row,
    output dz_cols_t         cols
);

    localparam int unsigned CNT_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

    logic [CNT_W-1:0] scan_cnt;
    logic             scan_tick;
    logic [ROW_W-1:0] idx_q;
    logic [ROW_W-1:0] idx_d; // lags idx_q by the rom latency
    logic [7:0]       row_dec;

    assign scan_tick = (scan_cnt == CNT_W'(SCAN_CYCLES - 1));

    // scan divider and row counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            idx_q    <= '0;
        end
        else if (scan_tick)
        begin
            scan_cnt <= '0;
            idx_q    <= idx_q + ROW_W'(1); // wraps 7 -> 0
        end
        else
            scan_cnt <= scan_cnt + CNT_W'(1);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            idx_d <= '0;
        else
            idx_d <= idx_q;
    end

    // one low bit selects the row
    assign row_dec = ~(8'b0000_0001 << idx_d);

    // row and columns switch on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'hFF;
            cols <= '0;
        end
        else
        begin
            row  <= row_dec;
            cols <= cols_in;
        end
    end

    assign row_idx = idx_q;

endmodule

`default_nettype wire

//--- dz_testdata.txt
# W addr data err | R addr data err | S digit running done | P cycles span
# F red rows 0-7 then green rows 0-7; all fields hex, P adds a random 0..span cycles
R 8 3e8 0
W 4 5 0
R 4 5 0
W 4 c 0
R 4 9 0
R 2 0 1
W c 0 1
W 4 4 0
W 8 14 0
R 8 14 0
W 0 1 0
S 4 1 0
S 3 1 0
S 2 1 0
S 1 1 0
S 0 0 1
F 00 00 00 00 00 00 00 00 00 77 45 45 55 55 77 00
W 8 40 0
W 0 1 0
S 4 1 0
W 0 2 0
F 00 00 24 24 24 3c 00 00 00 00 00 00 00 00 00 00
W 0 0 0
S 3 1 0
W 0 2 0
F 00 00 3c 24 24 24 00 00 00 00 00 00 00 00 00 00
R c e 0
P 20 60
R c e 0
W 0 0 0
S 2 1 0
W 0 2 0
F 00 00 3c 04 04 3c 00 00 00 00 00 00 00 00 00 00
W 0 0 0
S 1 1 0
W 0 2 0
F 00 3c 66 06 0c 30 60 7e 00 00 00 00 00 00 00 00
W 0 0 0
S 0 0 1
W 0 1 0
S 4 1 0
R c 12 0

//--- dz_top.sv
`timescale 1ns/100ps
`default_nettype none

module dz_top
    import dz_pkg::*;
#(
    parameter int unsigned SCAN_CYCLES = 4,
    parameter int unsigned STEP_RESET  = 1000
)
(
    input  logic        clk,
    input  logic        rst,
    input  dz_apb_req_t apb_req,
    output dz_apb_rsp_t apb_rsp,
    output logic [7:0]  row,
    output dz_cols_t    cols
);

    logic              start;
    logic              pause;
    dz_digit_t         load_digit;
    logic [STEP_W-1:0] step_cycles;
    dz_status_t        status;
    logic [ROW_W-1:0]  row_idx;
    dz_cols_t          rom_cols;

    dz_apb_regs #(
        .STEP_RESET (STEP_RESET)
    ) i_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .start       (start),
        .pause       (pause),
        .load_digit  (load_digit),
        .step_cycles (step_cycles),
        .status      (status)
    );

    dz_countdown i_countdown (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pause       (pause),
        .load_digit  (load_digit),
        .step_cycles (step_cycles),
        .status      (status)
    );

    dz_glyph_rom i_rom (
        .clk     (clk),
        .rst     (rst),
        .digit   (status.digit),
        .done    (status.done),
        .row_idx (row_idx),
        .cols    (rom_cols)
    );

    dz_show #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) i_show (
        .clk     (clk),
        .rst     (rst),
        .cols_in (rom_cols),
        .row_idx (row_idx),
        .row     (row),
        .cols    (cols)
    );

endmodule

`default_nettype wire

//--- tb_dz_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dz_top
    import dz_pkg::*;
();

    localparam int SCAN_CYCLES = 4;
    localparam int ROW_TIMEOUT = 9 * SCAN_CYCLES;
    localparam int POLL_LIMIT  = 2000;
    localparam int READY_LIMIT = 16;

    logic        clk;
    logic        rst;
    dz_apb_req_t apb_req;
    dz_apb_rsp_t apb_rsp;
    logic [7:0]  row;
    dz_cols_t    cols;

    int       errors;
    int       tests;
    int       failed;
    logic     aborted;
    dz_cols_t frame_exp [8];

    dz_top #(
        .SCAN_CYCLES (SCAN_CYCLES),
        .STEP_RESET  (1000)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .row     (row),
        .cols    (cols)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic give_up(input string why);
        $display("%s", why);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic check_word(input string name, input dz_word_t got, input dz_word_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_row(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input dz_status_t got, input dz_status_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got digit %h running %h done %h, expected %h %h %h",
                     name, got.digit, got.running, got.done,
                     exp.digit, exp.running, exp.done);
            errors++;
        end
    endtask

    task automatic check_cols(input string name, input dz_cols_t got, input dz_cols_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got red %h green %h, expected red %h green %h",
                     name, got.red, got.green, exp.red, exp.green);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic write, input dz_word_t addr, input dz_word_t wdata,
                            output dz_word_t rdata, output logic err);
        logic ready;
        rdata = '0;
        err   = 1'b0;
        ready = 1'b0;
        @(posedge clk);
        apb_req.psel    <= 1'b1; // setup phase
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= dz_addr_t'(addr);
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        for (int n = 0; n < READY_LIMIT && !ready; n++)
        begin
            @(negedge clk);
            ready = apb_rsp.pready;
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(posedge clk); // access ends on this edge once pready is seen
        end
        apb_req <= '0;
        if (!ready)
            give_up($sformatf("no pready from APB address %h", addr[3:0]));
    endtask

    task automatic wait_status(input dz_status_t exp);
        dz_word_t   rdata;
        dz_status_t got;
        logic       err;
        logic       seen;
        seen = 1'b0;
        got  = '0;
        for (int n = 0; n < POLL_LIMIT && !seen && !aborted; n++)
        begin
            apb_xfer(1'b0, dz_word_t'(ADDR_STATUS), '0, rdata, err);
            got  = dz_status_t'(rdata[$bits(dz_status_t)-1:0]);
            seen = (got.digit == exp.digit);
        end
        if (seen)
            check_status("status", got, exp);
        else if (!aborted)
            give_up($sformatf("STATUS never showed digit %0d", exp.digit));
    endtask

    task automatic check_frame();
        logic [7:0] want;
        logic       seen;
        repeat (2) @(posedge clk); // rom and scanner registers
        for (int r = 0; r < 8 && !aborted; r++)
        begin
            want = ~(8'h01 << r);
            seen = 1'b0;
            for (int n = 0; n < ROW_TIMEOUT && !seen; n++)
            begin
                @(negedge clk);
                seen = (row === want);
                // only the previous row may show while we wait
                if (!seen && r != 0 && row !== ~(8'h01 << (r - 1)))
                begin
                    check_row("row", row, want);
                    return;
                end
            end
            if (!seen)
                give_up($sformatf("row %0d never appeared on the row bus", r));
            else
                check_cols($sformatf("cols row %0d", r), cols, frame_exp[r]);
        end
    endtask

    task automatic finish_test(input string desc, input int err_base);
        tests++;
        if (errors != err_base)
            failed++;
        $display("%-24s %s", desc, (errors == err_base) ? "pass" : "fail");
    endtask

    initial
    begin
        int               fd;
        int               nf;
        int               got_f;
        int               err_base;
        logic [7:0]       cmd;
        logic [8*200-1:0] rest;
        dz_word_t         v [16];
        dz_word_t         rdata;
        logic             err;

        errors  = 0;
        tests   = 0;
        failed  = 0;
        aborted = 1'b0;
        void'($urandom(32'h2505f4ef));
        rst     = 1'b1;
        apb_req = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_row("row", row, 8'hFF); // dark until the first start
        check_cols("cols", cols, '0);
        finish_test("reset state", 0);

        fd = $fopen("dz_testdata.txt", "r");
        if (fd == 0)
            give_up("cannot open dz_testdata.txt");
        while (fd != 0 && !aborted && $fscanf(fd, " %c", cmd) == 1)
        begin
            if (cmd == "#")
            begin
                got_f = $fgets(rest, fd);
                continue;
            end
            case (cmd)
                "W", "R", "S": nf = 3;
                "F":           nf = 16;
                "P":           nf = 2;
                default:       nf = 0;
            endcase
            got_f = 0;
            for (int i = 0; i < nf; i++)
                got_f += $fscanf(fd, "%h", v[i]);
            err_base = errors;
            if (nf == 0 || got_f != nf)
                give_up($sformatf("bad command line starting with '%c'", cmd));
            else
            begin
                case (cmd)
                    "W":
                    begin
                        apb_xfer(1'b1, v[0], v[1], rdata, err);
                        check_flag("pslverr", err, v[2][0]);
                    end
                    "R":
                    begin
                        apb_xfer(1'b0, v[0], '0, rdata, err);
                        check_word("prdata", rdata, v[1]);
                        check_flag("pslverr", err, v[2][0]);
                    end
                    "S":
                        wait_status({dz_digit_t'(v[0]), v[1][0], v[2][0]});
                    "F":
                    begin
                        for (int i = 0; i < 8; i++)
                            frame_exp[i] = {v[i][7:0], v[i + 8][7:0]};
                        check_frame();
                    end
                    default: // P, base plus a random span
                        repeat (v[0] + $urandom % (v[1] + 32'd1)) @(posedge clk);
                endcase
                finish_test($sformatf("%c %0h %0h", cmd, v[0], v[1]), err_base);
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && !aborted)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
